/* Makefile */
SIM      = verilator
SIMFLAGS = --binary --timing --assert -j 0
TOP      = regfLsuTb
FILELIST = regfLsu.f
BUILDDIR = obj_dir
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+100
PASSMSG  = PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILDDIR) and $(LOG)"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR) -o V$(TOP)
	-./$(BUILDDIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASSMSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILDDIR) $(LOG)

/* regfLsu.f */
rtl/regfPkg.sv
rtl/regFile.sv
rtl/loadSizer.sv
rtl/storeSizer.sv
rtl/apbMaster.sv
rtl/regfLsuTop.sv
testbench/regfLsu_chk.sv
testbench/regfLsuTb.sv

/* rtl/apbMaster.sv */
// Command sequencer and APB master
//   Accepts one command at a time on a valid/ready handshake
//   Writes ALU and link results at acceptance
//   Runs APB setup and access phases for loads and stores
//   Writes load data back when pready is sampled

`timescale 1ns/1ps
`default_nettype none

module apbMaster #(
   parameter int AddrWidth = 16
) (
   input  logic                          gclk,
   input  logic                          grst,
   // Command port
   input  logic                          cmdValid,
   output logic                          cmdReady,
   input  regfPkg::lsuOp_e               cmdOp,
   input  regfPkg::memSize_e             cmdSize,
   input  logic [4:0]                    cmdRw,
   input  logic [AddrWidth-1:0]          cmdAddr,
   input  logic [regfPkg::DataWidth-1:0] cmdResult,
   input  logic [regfPkg::DataWidth-3:0] cmdPcLink,
   // Sizer side
   input  logic [regfPkg::DataWidth-1:0] loadData,
   input  logic [regfPkg::DataWidth-1:0] storeBus,
   input  logic [3:0]                    storeStrobe,
   output regfPkg::memSize_e             heldSize,
   output logic [1:0]                    heldOffset,
   // Register write port
   output logic                          wrEn,
   output logic [4:0]                    wrAddr,
   output logic [regfPkg::DataWidth-1:0] wrData,
   // APB master
   output logic [AddrWidth-1:0]          paddr,
   output logic                          psel,
   output logic                          penable,
   output logic                          pwrite,
   output logic [regfPkg::DataWidth-1:0] pwdata,
   output logic [3:0]                    pstrb,
   input  logic                          pready
);

   regfPkg::apbState_e            state;
   regfPkg::apbState_e            stateNext;
   logic                          accept;
   logic                          memCmd;
   logic                          loadDone;
   // Held transfer fields
   logic [AddrWidth-1:0]          heldAddr;
   logic [4:0]                    heldRw;
   logic                          heldWrite;
   logic [regfPkg::DataWidth-1:0] heldData;
   logic [3:0]                    heldStrb;

   assign accept = cmdValid && cmdReady;
   assign memCmd = (cmdOp == regfPkg::opLoad) || (cmdOp == regfPkg::opStore);

   // Idle until a memory command, then one setup cycle
   // Access holds until the slave raises pready
   always_comb begin
      stateNext = state;
      case (state)
         regfPkg::apbIdle: begin
            if (accept && memCmd) begin
               stateNext = regfPkg::apbSetup;
            end
         end
         regfPkg::apbSetup: stateNext = regfPkg::apbAccess;
         regfPkg::apbAccess: begin
            if (pready) begin
               stateNext = regfPkg::apbIdle;
            end
         end
         default: stateNext = regfPkg::apbIdle;
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         state <= regfPkg::apbIdle;
      end else begin
         state <= stateNext;
      end
   end

   // Capture memory command fields at acceptance
   // Store data is already sized and replicated
   always_ff @(posedge gclk) begin
      if (accept && memCmd) begin
         heldAddr  <= cmdAddr;
         heldSize  <= cmdSize;
         heldRw    <= cmdRw;
         heldWrite <= (cmdOp == regfPkg::opStore);
         heldData  <= storeBus;
         // Read transfers drive no strobes
         heldStrb  <= (cmdOp == regfPkg::opStore) ? storeStrobe : 4'b0000;
      end
   end

   // Ready only while no transfer is in flight
   assign cmdReady = (state == regfPkg::apbIdle);

   // APB outputs straight from state and held fields
   assign psel       = (state != regfPkg::apbIdle);
   assign penable    = (state == regfPkg::apbAccess);
   assign paddr      = {heldAddr[AddrWidth-1:2], 2'b00};
   assign pwrite     = heldWrite;
   assign pwdata     = heldData;
   assign pstrb      = heldStrb;
   assign heldOffset = heldAddr[1:0];

   // Load completes on the edge that samples pready
   assign loadDone = penable && pready && !heldWrite;

   // Writeback mux: ALU result, link address or load data
   // Accept and loadDone never overlap since accept needs idle
   always_comb begin
      wrEn   = 1'b0;
      wrAddr = cmdRw;
      wrData = cmdResult;
      if (loadDone) begin
         wrEn   = (heldRw != 5'd0);
         wrAddr = heldRw;
         wrData = loadData;
      end else if (accept) begin
         case (cmdOp)
            regfPkg::opAlu: begin
               wrEn = (cmdRw != 5'd0);
            end
            regfPkg::opLink: begin
               wrEn   = (cmdRw != 5'd0);
               wrData = {cmdPcLink, 2'b00};
            end
            default: wrEn = 1'b0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/loadSizer.sv */
// Load sizer
//   Picks a byte or halfword lane out of a big-endian bus word
//   Zero-extends the lane to a full word

`timescale 1ns/1ps
`default_nettype none

module loadSizer (
   input  regfPkg::memSize_e             size,
   input  logic [1:0]                    offset,
   input  logic [regfPkg::DataWidth-1:0] busData,
   output logic [regfPkg::DataWidth-1:0] loadData
);

   // Lane select by big-endian order
   // Offset 0 is the most significant lane
   always_comb begin
      case (size)
         regfPkg::szByte: begin
            case (offset)
               2'd0:    loadData = {24'd0, busData[31:24]};
               2'd1:    loadData = {24'd0, busData[23:16]};
               2'd2:    loadData = {24'd0, busData[15:8]};
               default: loadData = {24'd0, busData[7:0]};
            endcase
         end
         regfPkg::szHalf: begin
            // Only offsets 0 and 2 are aligned
            if (offset[1]) begin
               loadData = {16'd0, busData[15:0]};
            end else begin
               loadData = {16'd0, busData[31:16]};
            end
         end
         // Word passes straight through
         default: loadData = busData;
      endcase
   end

endmodule

`default_nettype wire

/* rtl/regFile.sv */
// General register file
//   31 writable words, R0 reads as zero
//   Two operand read ports and one store-data read port
//   One synchronous write port, combinational reads

`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  logic                          gclk,
   input  logic                          grst,
   // Operand read ports
   input  logic [4:0]                    rdAddrA,
   input  logic [4:0]                    rdAddrB,
   // Store data read port
   input  logic [4:0]                    rdAddrD,
   output logic [regfPkg::DataWidth-1:0] rdDataA,
   output logic [regfPkg::DataWidth-1:0] rdDataB,
   output logic [regfPkg::DataWidth-1:0] rdDataD,
   // Write port
   input  logic                          wrEn,
   input  logic [4:0]                    wrAddr,
   input  logic [regfPkg::DataWidth-1:0] wrData
);

   // No storage behind R0
   logic [regfPkg::DataWidth-1:0] regs [1:31];

   // Zero for R0, array word otherwise
   function automatic logic [regfPkg::DataWidth-1:0] readReg(input logic [4:0] addr);
      logic [regfPkg::DataWidth-1:0] value;
      if (addr == 5'd0) begin
         value = '0;
      end else begin
         value = regs[addr];
      end
      return value;
   endfunction

   // All words clear on reset
   // Writes to R0 are dropped here as well
   always_ff @(posedge gclk) begin
      if (grst) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && (wrAddr != 5'd0)) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Operand ports feed the ALU directly
   assign rdDataA = readReg(rdAddrA);
   assign rdDataB = readReg(rdAddrB);

   // store data goes to the store sizer
   assign rdDataD = readReg(rdAddrD);

endmodule

`default_nettype wire

/* rtl/regfLsuTop.sv */
// Register file and load/store data path top level
//   Command port in, ALU operands out
//   APB master port to data memory
//   Register file, load and store sizers, APB sequencer

`timescale 1ns/1ps
`default_nettype none

module regfLsuTop #(
   parameter int AddrWidth = 16
) (
   input  logic                          gclk,
   input  logic                          grst,
   // Command port
   input  logic                          cmdValid,
   output logic                          cmdReady,
   input  regfPkg::lsuOp_e               cmdOp,
   input  regfPkg::memSize_e             cmdSize,
   input  logic [4:0]                    cmdRa,
   input  logic [4:0]                    cmdRb,
   input  logic [4:0]                    cmdRd,
   input  logic [4:0]                    cmdRw,
   input  logic [AddrWidth-1:0]          cmdAddr,
   input  logic [regfPkg::DataWidth-1:0] cmdResult,
   input  logic [regfPkg::DataWidth-3:0] cmdPcLink,
   // ALU operands
   output logic [regfPkg::DataWidth-1:0] opA,
   output logic [regfPkg::DataWidth-1:0] opB,
   // APB master port
   output logic [AddrWidth-1:0]          paddr,
   output logic                          psel,
   output logic                          penable,
   output logic                          pwrite,
   output logic [regfPkg::DataWidth-1:0] pwdata,
   output logic [3:0]                    pstrb,
   input  logic [regfPkg::DataWidth-1:0] prdata,
   input  logic                          pready
);

   logic                          wrEn;
   logic [4:0]                    wrAddr;
   logic [regfPkg::DataWidth-1:0] wrData;
   logic [regfPkg::DataWidth-1:0] storeData;
   logic [regfPkg::DataWidth-1:0] storeBus;
   logic [3:0]                    storeStrobe;
   logic [regfPkg::DataWidth-1:0] loadData;
   regfPkg::memSize_e             heldSize;
   logic [1:0]                    heldOffset;

   // Register array, port D supplies store data
   regFile i_regFile (
      .gclk    (gclk),
      .grst    (grst),
      .rdAddrA (cmdRa),
      .rdAddrB (cmdRb),
      .rdAddrD (cmdRd),
      .rdDataA (opA),
      .rdDataB (opB),
      .rdDataD (storeData),
      .wrEn    (wrEn),
      .wrAddr  (wrAddr),
      .wrData  (wrData)
   );

   // Sized from the live command, latched by the master at acceptance
   storeSizer i_storeSizer (
      .size      (cmdSize),
      .offset    (cmdAddr[1:0]),
      .storeData (storeData),
      .busData   (storeBus),
      .strobe    (storeStrobe)
   );

   // Uses the held size and offset of the transfer in flight
   loadSizer i_loadSizer (
      .size     (heldSize),
      .offset   (heldOffset),
      .busData  (prdata),
      .loadData (loadData)
   );

   apbMaster #(
      .AddrWidth (AddrWidth)
   ) i_apbMaster (
      .gclk        (gclk),
      .grst        (grst),
      .cmdValid    (cmdValid),
      .cmdReady    (cmdReady),
      .cmdOp       (cmdOp),
      .cmdSize     (cmdSize),
      .cmdRw       (cmdRw),
      .cmdAddr     (cmdAddr),
      .cmdResult   (cmdResult),
      .cmdPcLink   (cmdPcLink),
      .loadData    (loadData),
      .storeBus    (storeBus),
      .storeStrobe (storeStrobe),
      .heldSize    (heldSize),
      .heldOffset  (heldOffset),
      .wrEn        (wrEn),
      .wrAddr      (wrAddr),
      .wrData      (wrData),
      .paddr       (paddr),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .pstrb       (pstrb),
      .pready      (pready)
   );

endmodule

`default_nettype wire

/* rtl/regfPkg.sv */
// Shared definitions for the register file and load/store path
//   DataWidth   data word width
//   lsuOp_e     command opcodes
//   memSize_e   memory access sizes
//   apbState_e  APB sequencer states

`default_nettype none

package regfPkg;

   // Byte lane logic assumes four lanes
   localparam int DataWidth = 32;

   // Command opcodes from the decode stand-in
   typedef enum logic [2:0] {
      opNop   = 3'd0,
      opAlu   = 3'd1,
      opLink  = 3'd2,
      opLoad  = 3'd3,
      opStore = 3'd4
   } lsuOp_e;

   // Access size for loads and stores
   typedef enum logic [1:0] {
      szByte = 2'd0,
      szHalf = 2'd1,
      szWord = 2'd2
   } memSize_e;

   // Bus sequencer states
   typedef enum logic [1:0] {
      apbIdle   = 2'd0,
      apbSetup  = 2'd1,
      apbAccess = 2'd2
   } apbState_e;

endpackage

`default_nettype wire

/* rtl/storeSizer.sv */
// Store sizer
//   Replicates store data across the byte lanes
//   Derives APB byte strobes from size and offset

`timescale 1ns/1ps
`default_nettype none

module storeSizer (
   input  regfPkg::memSize_e             size,
   input  logic [1:0]                    offset,
   input  logic [regfPkg::DataWidth-1:0] storeData,
   output logic [regfPkg::DataWidth-1:0] busData,
   output logic [3:0]                    strobe
);

   // Strobe bit 3 covers bits 31:24, which is offset 0
   always_comb begin
      case (size)
         regfPkg::szByte: begin
            // Low byte on every lane
            busData = {4{storeData[7:0]}};
            strobe  = 4'b1000 >> offset;
         end
         regfPkg::szHalf: begin
            // Low halfword on both halves
            busData = {2{storeData[15:0]}};
            if (offset[1]) begin
               strobe = 4'b0011;
            end else begin
               strobe = 4'b1100;
            end
         end
         default: begin
            busData = storeData;
            strobe  = 4'b1111;
         end
      endcase
   end

endmodule

`default_nettype wire

/* testbench/regfLsuTb.sv */
// Testbench for the register file and load/store path
//   Clock, reset and xorshift stimulus on the command port
//   APB memory model with random wait states
//   Shadow register file and memory as reference model
//   Compare process on opA, opB and memory words

`timescale 1ns/1ps
`default_nettype none

module regfLsuTb;

   localparam int AddrWidth     = 16;
   localparam int NumRandom     = 400;
   localparam int NumDirected   = 40;
   localparam int TimeoutCycles = (NumRandom + NumDirected) * 10 + 1000;

   logic                 gclk = 1'b0;
   logic                 grst;
   logic                 cmdValid;
   logic                 cmdReady;
   regfPkg::lsuOp_e      cmdOp;
   regfPkg::memSize_e    cmdSize;
   logic [4:0]           cmdRa;
   logic [4:0]           cmdRb;
   logic [4:0]           cmdRd;
   logic [4:0]           cmdRw;
   logic [AddrWidth-1:0] cmdAddr;
   logic [31:0]          cmdResult;
   logic [29:0]          cmdPcLink;
   logic [31:0]          opA;
   logic [31:0]          opB;
   logic [AddrWidth-1:0] paddr;
   logic                 psel;
   logic                 penable;
   logic                 pwrite;
   logic [31:0]          pwdata;
   logic [3:0]           pstrb;
   logic [31:0]          prdata;
   logic                 pready;

   // Memory model, shadow state and check controls
   logic [31:0] mem [0:255];
   logic [31:0] shadowMem [0:255];
   logic [31:0] shadowRegs [0:31];
   logic [31:0] rng;
   logic [31:0] waitRng;
   logic [1:0]  waitLeft;
   logic        regCheckOn;
   logic        memCheckOn;
   logic [31:0] expA;
   logic [31:0] expB;
   logic [7:0]  checkIdx;
   string       testName;
   int          checkCount;
   int          errorCount;

   regfLsuTop #(
      .AddrWidth (AddrWidth)
   ) i_regfLsuTop (
      .gclk      (gclk),
      .grst      (grst),
      .cmdValid  (cmdValid),
      .cmdReady  (cmdReady),
      .cmdOp     (cmdOp),
      .cmdSize   (cmdSize),
      .cmdRa     (cmdRa),
      .cmdRb     (cmdRb),
      .cmdRd     (cmdRd),
      .cmdRw     (cmdRw),
      .cmdAddr   (cmdAddr),
      .cmdResult (cmdResult),
      .cmdPcLink (cmdPcLink),
      .opA       (opA),
      .opB       (opB),
      .paddr     (paddr),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .pwdata    (pwdata),
      .pstrb     (pstrb),
      .prdata    (prdata),
      .pready    (pready)
   );

   always #2 gclk = ~gclk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic regfPkg::memSize_e pickSize(input logic [1:0] code);
      regfPkg::memSize_e size;
      if (code == 2'd0) begin
         size = regfPkg::szByte;
      end else if (code == 2'd1) begin
         size = regfPkg::szHalf;
      end else begin
         size = regfPkg::szWord;
      end
      return size;
   endfunction

   function automatic int byteCount(input regfPkg::memSize_e size);
      int nb;
      if (size == regfPkg::szByte) begin
         nb = 1;
      end else if (size == regfPkg::szHalf) begin
         nb = 2;
      end else begin
         nb = 4;
      end
      return nb;
   endfunction

   // Big-endian lane read, lowest offset is the top byte
   function automatic logic [31:0] laneRead(input logic [31:0] word,
                                            input regfPkg::memSize_e size,
                                            input logic [1:0] offset);
      int          nb;
      int          shift;
      logic [31:0] mask;
      nb    = byteCount(size);
      shift = (4 - int'(offset) - nb) * 8;
      mask  = (nb == 4) ? 32'hFFFF_FFFF : ((32'd1 << (8 * nb)) - 32'd1);
      return (word >> shift) & mask;
   endfunction

   // Most significant data byte lands on the lowest addressed lane
   function automatic logic [31:0] laneWrite(input logic [31:0] word,
                                             input regfPkg::memSize_e size,
                                             input logic [1:0] offset,
                                             input logic [31:0] data);
      logic [31:0] result;
      int          nb;
      int          src;
      result = word;
      nb     = byteCount(size);
      for (int lane = 0; lane < 4; lane++) begin
         if (lane >= int'(offset) && lane < int'(offset) + nb) begin
            src = nb - 1 - (lane - int'(offset));
            result[31 - 8 * lane -: 8] = data[8 * src +: 8];
         end
      end
      return result;
   endfunction

   // Reference model, one accepted command
   function automatic void refModel(input regfPkg::lsuOp_e op, input regfPkg::memSize_e size,
                                    input logic [4:0] rd, input logic [4:0] rw,
                                    input logic [15:0] addr, input logic [31:0] result,
                                    input logic [29:0] pcLink);
      logic [7:0] idx;
      idx = addr[9:2];
      if (op == regfPkg::opStore) begin
         shadowMem[idx] = laneWrite(shadowMem[idx], size, addr[1:0], shadowRegs[rd]);
      end else if (rw != 5'd0) begin
         case (op)
            regfPkg::opAlu:  shadowRegs[rw] = result;
            regfPkg::opLink: shadowRegs[rw] = {pcLink, 2'b00};
            regfPkg::opLoad: shadowRegs[rw] = laneRead(shadowMem[idx], size, addr[1:0]);
            default: ;
         endcase
      end
   endfunction

   // APB slave, everything at the falling edge
   // Setup picks 0 to 3 wait states, the write lands with pready
   always @(negedge gclk) begin
      if (grst || !psel) begin
         pready = 1'b0;
      end else if (!penable) begin
         waitRng  = xorshift(waitRng);
         waitLeft = waitRng[1:0];
         pready   = 1'b0;
      end else if (waitLeft != 2'd0) begin
         waitLeft = waitLeft - 2'd1;
         pready   = 1'b0;
      end else begin
         pready = 1'b1;
         prdata = mem[paddr[9:2]];
         if (pwrite) begin
            for (int b = 0; b < 4; b++) begin
               if (pstrb[b]) begin
                  mem[paddr[9:2]][8 * b +: 8] = pwdata[8 * b +: 8];
               end
            end
         end
      end
   end

   // Compare at the rising edge, inputs settled since the falling edge
   always @(posedge gclk) begin
      if (regCheckOn) begin
         checkCount++;
         if (opA !== expA) begin
            errorCount++;
            $display("** Error [%s] opA R%0d: expected %08h, actual %08h",
                     testName, cmdRa, expA, opA);
         end
         if (opB !== expB) begin
            errorCount++;
            $display("** Error [%s] opB R%0d: expected %08h, actual %08h",
                     testName, cmdRb, expB, opB);
         end
      end
      if (memCheckOn) begin
         checkCount++;
         if (mem[checkIdx] !== shadowMem[checkIdx]) begin
            errorCount++;
            $display("** Error [%s] mem[%0d]: expected %08h, actual %08h",
                     testName, checkIdx, shadowMem[checkIdx], mem[checkIdx]);
         end
      end
   end

   task automatic randWord(output logic [31:0] r);
      rng = xorshift(rng);
      r   = rng;
   endtask

   // Called and returns at a falling edge
   task automatic checkRegs(input logic [4:0] a, input logic [4:0] b);
      cmdRa      = a;
      cmdRb      = b;
      expA       = shadowRegs[a];
      expB       = shadowRegs[b];
      regCheckOn = 1'b1;
      @(negedge gclk);
      regCheckOn = 1'b0;
   endtask

   task automatic checkMem(input logic [7:0] idx);
      checkIdx   = idx;
      memCheckOn = 1'b1;
      @(negedge gclk);
      memCheckOn = 1'b0;
   endtask

   // One command, then wait for cmdReady to mark completion
   task automatic issueCmd(input regfPkg::lsuOp_e op, input regfPkg::memSize_e size,
                           input logic [4:0] rd, input logic [4:0] rw,
                           input logic [15:0] addr, input logic [31:0] result,
                           input logic [29:0] pcLink);
      while (!cmdReady) begin
         @(negedge gclk);
      end
      cmdOp     = op;
      cmdSize   = size;
      cmdRd     = rd;
      cmdRw     = rw;
      cmdAddr   = addr;
      cmdResult = result;
      cmdPcLink = pcLink;
      cmdValid  = 1'b1;
      @(negedge gclk);
      cmdValid = 1'b0;
      refModel(op, size, rd, rw, addr, result, pcLink);
      while (!cmdReady) begin
         @(negedge gclk);
      end
   endtask

   // Watchdog sized from the command count
   initial begin
      repeat (TimeoutCycles) @(posedge gclk);
      $display("Watchdog: run did not finish within %0d cycles", TimeoutCycles);
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      int                i;
      int                s;
      int                off;
      int                k;
      int                totalErrors;
      logic [31:0]       r;
      logic [31:0]       r2;
      logic [7:0]        w;
      logic [7:0]        wIdx;
      logic [1:0]        offBits;
      logic [15:0]       addr;
      regfPkg::lsuOp_e   op;
      regfPkg::memSize_e size;

      rng        = 32'd61;
      waitRng    = 32'd61;
      grst       = 1'b1;
      cmdValid   = 1'b0;
      cmdOp      = regfPkg::opNop;
      cmdSize    = regfPkg::szWord;
      cmdRa      = 5'd0;
      cmdRb      = 5'd0;
      cmdRd      = 5'd0;
      cmdRw      = 5'd0;
      cmdAddr    = '0;
      cmdResult  = '0;
      cmdPcLink  = '0;
      prdata     = '0;
      pready     = 1'b0;
      waitLeft   = 2'd0;
      regCheckOn = 1'b0;
      memCheckOn = 1'b0;
      expA       = '0;
      expB       = '0;
      checkIdx   = '0;
      checkCount = 0;
      errorCount = 0;
      testName   = "reset";
      // Distinct bytes per lane, pattern follows the word index
      for (i = 0; i < 256; i++) begin
         w            = i[7:0];
         mem[i]       = {w, ~w, w ^ 8'h5A, w + 8'h33};
         shadowMem[i] = mem[i];
      end
      for (i = 0; i < 32; i++) begin
         shadowRegs[i] = '0;
      end
      repeat (3) @(negedge gclk);
      grst = 1'b0;

      // All registers zero, ready after reset
      if (cmdReady !== 1'b1) begin
         errorCount++;
         $display("** Error [%s] cmdReady: expected 1, actual %b", testName, cmdReady);
      end
      for (i = 0; i < 32; i++) begin
         s = 31 - i;
         checkRegs(i[4:0], s[4:0]);
      end

      testName = "aluLink";
      issueCmd(regfPkg::opAlu, regfPkg::szWord, 5'd0, 5'd5, 16'd0, 32'hDEAD_BEEF, 30'd0);
      issueCmd(regfPkg::opLink, regfPkg::szWord, 5'd0, 5'd7, 16'd0, 32'd0, 30'h0ABC_1234);
      issueCmd(regfPkg::opAlu, regfPkg::szWord, 5'd0, 5'd0, 16'd0, 32'hFFFF_FFFF, 30'd0);
      issueCmd(regfPkg::opLink, regfPkg::szWord, 5'd0, 5'd0, 16'd0, 32'd0, 30'h3FFF_FFFF);
      issueCmd(regfPkg::opAlu, regfPkg::szWord, 5'd0, 5'd31, 16'd0, 32'h1234_5678, 30'd0);
      checkRegs(5'd5, 5'd5);
      checkRegs(5'd7, 5'd7);
      checkRegs(5'd0, 5'd0);
      checkRegs(5'd31, 5'd31);

      // Every aligned size and offset, one fresh word each
      testName = "store";
      k = 0;
      for (s = 0; s < 3; s++) begin
         for (off = 0; off < 4; off++) begin
            size = pickSize(s[1:0]);
            if (off % byteCount(size) == 0) begin
               randWord(r);
               wIdx = 8'd16 + k[7:0];
               addr = {6'd0, wIdx, off[1:0]};
               issueCmd(regfPkg::opAlu, regfPkg::szWord, 5'd0, 5'd10, 16'd0, r, 30'd0);
               issueCmd(regfPkg::opStore, size, 5'd10, 5'd0, addr, 32'd0, 30'd0);
               checkMem(wIdx);
               k++;
            end
         end
      end

      testName = "load";
      k = 0;
      for (s = 0; s < 3; s++) begin
         for (off = 0; off < 4; off++) begin
            size = pickSize(s[1:0]);
            if (off % byteCount(size) == 0) begin
               wIdx = 8'd64 + k[7:0];
               addr = {6'd0, wIdx, off[1:0]};
               issueCmd(regfPkg::opLoad, size, 5'd0, 5'd12, addr, 32'd0, 30'd0);
               checkRegs(5'd12, 5'd12);
               k++;
            end
         end
      end

      // Opcode weights lean toward memory traffic
      testName = "random";
      for (i = 0; i < NumRandom; i++) begin
         randWord(r);
         randWord(r2);
         case (r[2:0])
            3'd0:         op = regfPkg::opNop;
            3'd1, 3'd7:   op = regfPkg::opAlu;
            3'd2:         op = regfPkg::opLink;
            3'd3, 3'd5:   op = regfPkg::opLoad;
            default:      op = regfPkg::opStore;
         endcase
         size    = pickSize(r[14:13]);
         offBits = r[24:23];
         if (size == regfPkg::szHalf) begin
            offBits[0] = 1'b0;
         end else if (size == regfPkg::szWord) begin
            offBits = 2'd0;
         end
         addr = {6'd0, r[22:15], offBits};
         issueCmd(op, size, r[7:3], r[12:8], addr, r2, r2[29:0]);
         checkRegs(r[12:8], r[7:3]);
      end

      testName = "final";
      for (i = 0; i < 32; i++) begin
         s = 31 - i;
         checkRegs(i[4:0], s[4:0]);
      end
      for (i = 0; i < 256; i++) begin
         checkMem(i[7:0]);
      end

      totalErrors = errorCount + i_regfLsuTop.i_apbMaster.i_apbMasterChk.failCount;
      $display("Checks: %0d, compare errors: %0d, assertion failures: %0d",
               checkCount, errorCount, i_regfLsuTop.i_apbMaster.i_apbMasterChk.failCount);
      if (totalErrors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* testbench/regfLsu_chk.sv */
// APB protocol and command handshake assertions
//   Bound onto apbMaster
//   Counts its own failures for the testbench summary

`timescale 1ns/1ps
`default_nettype none

module apbMasterChk #(
   parameter int AddrWidth = 16
) (
   input  logic                 gclk,
   input  logic                 grst,
   input  logic                 cmdReady,
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  logic [AddrWidth-1:0] paddr,
   input  logic                 wrEn,
   input  logic [4:0]           wrAddr
);

   int failCount = 0;

   // Access only after a setup cycle
   assert property (@(posedge gclk) disable iff (grst) penable |-> (psel && $past(psel)))
      else begin
         failCount++;
         $error("penable high without psel in the previous cycle");
      end

   // Address and direction hold through access
   assert property (@(posedge gclk) disable iff (grst)
                    (psel && penable) |-> ($stable(paddr) && $stable(pwrite)))
      else begin
         failCount++;
         $error("paddr or pwrite changed during the access phase");
      end

   // No new command while a transfer runs
   assert property (@(posedge gclk) disable iff (grst) psel |-> !cmdReady)
      else begin
         failCount++;
         $error("cmdReady high while psel is high");
      end

   // R0 is never a write target
   assert property (@(posedge gclk) disable iff (grst) wrEn |-> (wrAddr != 5'd0))
      else begin
         failCount++;
         $error("register write enabled for R0");
      end

endmodule

bind apbMaster apbMasterChk #(
   .AddrWidth (AddrWidth)
) i_apbMasterChk (
   .gclk     (gclk),
   .grst     (grst),
   .cmdReady (cmdReady),
   .psel     (psel),
   .penable  (penable),
   .pwrite   (pwrite),
   .paddr    (paddr),
   .wrEn     (wrEn),
   .wrAddr   (wrAddr)
);

`default_nettype wire
